//--- common/sdc_pkg.sv
package sdc_pkg;

  ////////////////////////////////////////
  // Register map, byte offsets
  ////////////////////////////////////////
  localparam logic [7:0] ADR_ARG     = 8'h00;  // Command argument
  localparam logic [7:0] ADR_CMD     = 8'h04;  // Command setting, write launches
  localparam logic [7:0] ADR_STATUS  = 8'h08;  // Bit 0 busy
  localparam logic [7:0] ADR_RESP    = 8'h0C;  // Response argument
  localparam logic [7:0] ADR_NISR    = 8'h10;  // Normal interrupt status
  localparam logic [7:0] ADR_EISR    = 8'h14;  // Error interrupt status
  localparam logic [7:0] ADR_NIEN    = 8'h18;  // Normal interrupt enable
  localparam logic [7:0] ADR_EIEN    = 8'h1C;  // Error interrupt enable
  localparam logic [7:0] ADR_TIMEOUT = 8'h20;  // Response timeout, cycles
  localparam logic [7:0] ADR_CARD    = 8'h24;  // Decoded card state

  // Command setting word fields
  localparam int SET_RSP_LSB = 0;
  localparam int SET_RSP_MSB = 1;
  localparam int SET_CRC_CHK = 3;   // Check response CRC
  localparam int SET_IDX_CHK = 4;   // Check response index
  localparam int SET_IDX_LSB = 8;
  localparam int SET_IDX_MSB = 13;

  typedef enum logic [1:0] {
    RSP_NONE = 2'd0,
    RSP_R1   = 2'd1,
    RSP_R3   = 2'd2
  } rsp_type_e;

  localparam int FRAME_BITS = 48;   // Token length, command and response

  ////////////////////////////////////////
  // Interrupt status bits
  ////////////////////////////////////////
  localparam int ISR_W       = 16;
  localparam int NI_CMD_DONE = 0;
  localparam int NI_ERR      = 15;  // Any error bit
  localparam int EI_TIMEOUT  = 0;
  localparam int EI_CRC      = 1;
  localparam int EI_END      = 2;
  localparam int EI_INDEX    = 3;

  // Response argument, R1 card status or R3 OCR
  typedef union packed {
    struct packed {
      logic [18:0] err_flags;   // Card error flags
      logic [3:0]  cur_state;   // Current card state
      logic        rdy_data;    // Ready for data
      logic [7:0]  rsvd;
    } r1;
    struct packed {
      logic        pwr_busy;    // Power-up status
      logic [6:0]  rsvd_hi;
      logic [8:0]  vdd_win;     // Voltage window
      logic [14:0] rsvd_lo;
    } ocr;
  } resp_arg_u;

endpackage

//--- hw/sdc_reg_decode.sv
`timescale 1ns/100ps

module sdc_reg_decode import sdc_pkg::*; #(
  parameter int TIMEOUT_W = 16
) (
  input  logic                 wb_clk_i,
  input  logic                 rst_i,
  input  logic [7:0]           wb_adr_i,
  input  logic [31:0]          wb_dat_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 cmd_ready_i,
  input  logic                 rsp_valid_i,
  input  logic [ISR_W-1:0]     nisr_i,
  input  logic [ISR_W-1:0]     eisr_i,
  input  resp_arg_u            resp_i,
  input  logic [3:0]           card_state_i,
  output logic                 cmd_valid_o,
  output logic [5:0]           cmd_index_o,
  output logic [31:0]          cmd_arg_o,
  output rsp_type_e            rsp_type_o,
  output logic                 crc_chk_o,
  output logic                 idx_chk_o,
  output logic [TIMEOUT_W-1:0] timeout_o,
  output logic [ISR_W-1:0]     nisr_clr_o,
  output logic [ISR_W-1:0]     eisr_clr_o,
  output logic [ISR_W-1:0]     nien_o,
  output logic [ISR_W-1:0]     eien_o
);

  logic                 acc;        // One cycle per bus access
  logic                 wr;
  logic                 launch;
  logic [31:0]          arg_q;      // Software view of argument
  logic [31:0]          cmd_arg_q;  // Argument of launched command
  logic [15:0]          set_q;
  logic [TIMEOUT_W-1:0] timeout_q;
  logic [ISR_W-1:0]     nien_q;
  logic [ISR_W-1:0]     eien_q;
  logic                 busy_q;
  logic                 valid_q;

  assign acc    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr     = acc & wb_we_i;
  assign launch = wr && (wb_adr_i == ADR_CMD) && !busy_q;  // Dropped while busy

  ////////////////////////////////////////
  // Bus acknowledge and control registers
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wb_ack_o  <= 1'b0;
      timeout_q <= '1;  // Longest wait
      nien_q    <= '0;
      eien_q    <= '0;
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      wb_ack_o <= acc;  // Single pulse, acc masked by ack
      if (wr && wb_adr_i == ADR_TIMEOUT) timeout_q <= wb_dat_i[TIMEOUT_W-1:0];
      if (wr && wb_adr_i == ADR_NIEN) nien_q <= wb_dat_i[ISR_W-1:0];
      if (wr && wb_adr_i == ADR_EIEN) eien_q <= wb_dat_i[ISR_W-1:0];
      // Busy spans launch to response
      if (launch) begin
        busy_q <= 1'b1;
      end else if (rsp_valid_i) begin
        busy_q <= 1'b0;
      end
      // Pending command until execute takes it
      if (launch) begin
        valid_q <= 1'b1;
      end else if (cmd_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Argument and setting words
  always_ff @(posedge wb_clk_i) begin
    if (wr && wb_adr_i == ADR_ARG) arg_q <= wb_dat_i;
    if (launch) begin
      set_q     <= wb_dat_i[15:0];
      cmd_arg_q <= arg_q;  // Snapshot, later ARG writes stay out
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      ADR_ARG:     wb_dat_o = arg_q;
      ADR_CMD:     wb_dat_o = {16'h0000, set_q};
      ADR_STATUS:  wb_dat_o = {31'h0, busy_q};
      ADR_RESP:    wb_dat_o = resp_i;
      ADR_NISR:    wb_dat_o = 32'(nisr_i);
      ADR_EISR:    wb_dat_o = 32'(eisr_i);
      ADR_NIEN:    wb_dat_o = 32'(nien_q);
      ADR_EIEN:    wb_dat_o = 32'(eien_q);
      ADR_TIMEOUT: wb_dat_o = 32'(timeout_q);
      ADR_CARD:    wb_dat_o = 32'(card_state_i);
      default:     wb_dat_o = '0;  // Unmapped reads as zero
    endcase
  end

  // Write-one-to-clear masks, one cycle
  assign nisr_clr_o = (wr && wb_adr_i == ADR_NISR) ? wb_dat_i[ISR_W-1:0] : '0;
  assign eisr_clr_o = (wr && wb_adr_i == ADR_EISR) ? wb_dat_i[ISR_W-1:0] : '0;

  assign cmd_valid_o = valid_q;
  assign cmd_index_o = set_q[SET_IDX_MSB:SET_IDX_LSB];
  assign cmd_arg_o   = cmd_arg_q;
  assign rsp_type_o  = rsp_type_e'(set_q[SET_RSP_MSB:SET_RSP_LSB]);
  assign crc_chk_o   = set_q[SET_CRC_CHK];
  assign idx_chk_o   = set_q[SET_IDX_CHK];
  assign timeout_o   = timeout_q;
  assign nien_o      = nien_q;
  assign eien_o      = eien_q;

  // Offered command holds until execute accepts
  a_cmd_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o &&
      $stable({cmd_index_o, cmd_arg_o, rsp_type_o, crc_chk_o, idx_chk_o}));

endmodule

//--- cmd_phy/sdc_cmd_serial.sv
`timescale 1ns/100ps

module sdc_cmd_serial import sdc_pkg::*; #(
  parameter int TIMEOUT_W = 16
) (
  input  logic                 wb_clk_i,
  input  logic                 rst_i,
  input  logic                 cmd_valid_i,
  input  logic [5:0]           cmd_index_i,
  input  logic [31:0]          cmd_arg_i,
  input  rsp_type_e            rsp_type_i,
  input  logic [TIMEOUT_W-1:0] timeout_i,
  input  logic                 sd_cmd_dat_i,
  output logic                 cmd_ready_o,
  output logic                 sd_cmd_out_o,
  output logic                 sd_cmd_oe_o,
  output logic                 rsp_valid_o,
  output logic [5:0]           rsp_index_o,
  output resp_arg_u            rsp_arg_o,
  output logic                 crc_ok_o,
  output logic                 end_ok_o,
  output logic                 timed_out_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_SEND = 2'd1;  // Token on the line
  localparam logic [1:0] ST_WAIT = 2'd2;  // Line released, hunt start bit
  localparam logic [1:0] ST_RECV = 2'd3;

  localparam logic [6:0] CRC7_POLY = 7'h09;              // x^7 + x^3 + 1
  localparam logic [5:0] LAST_BIT  = 6'(FRAME_BITS - 1);
  localparam logic [5:0] CRC_POS   = 6'd8;               // Last bit covered by CRC

  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
  endfunction

  logic [1:0]            state_q;
  logic [5:0]            cnt_q;      // Frame position of current bit
  logic [TIMEOUT_W-1:0]  tmo_q;
  logic [FRAME_BITS-1:0] tx_q;
  logic [FRAME_BITS-2:0] rx_q;       // All bits after the start bit
  logic [6:0]            crc_q;
  logic [6:0]            crc_nxt;
  rsp_type_e             type_q;
  logic                  oe_q;
  logic                  rsp_valid_q;
  logic                  timed_out_q;

  // One CRC register, outgoing or incoming bit
  assign crc_nxt = crc7_step(crc_q, (state_q == ST_SEND) ? tx_q[FRAME_BITS-1] : sd_cmd_dat_i);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      cnt_q       <= '0;
      tmo_q       <= '0;
      oe_q        <= 1'b0;
      rsp_valid_q <= 1'b0;
      timed_out_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;  // Pulse
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            state_q     <= ST_SEND;
            oe_q        <= 1'b1;
            cnt_q       <= LAST_BIT;
            timed_out_q <= 1'b0;
          end
        end
        ST_SEND: begin
          if (cnt_q == '0) begin  // End bit on the line
            oe_q  <= 1'b0;
            tmo_q <= '0;
            if (type_q == RSP_NONE) begin
              state_q     <= ST_IDLE;
              rsp_valid_q <= 1'b1;
            end else begin
              state_q <= ST_WAIT;
            end
          end else begin
            cnt_q <= cnt_q - 6'd1;
          end
        end
        ST_WAIT: begin
          if (!sd_cmd_dat_i) begin
            state_q <= ST_RECV;
            cnt_q   <= LAST_BIT - 6'd1;  // Start bit already seen
          end else if (tmo_q == timeout_i) begin
            state_q     <= ST_IDLE;
            timed_out_q <= 1'b1;
            rsp_valid_q <= 1'b1;
          end else begin
            tmo_q <= tmo_q + 1'b1;
          end
        end
        default: begin  // ST_RECV
          if (cnt_q == '0) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 6'd1;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Shift registers and CRC
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          // Start 0, direction 1, CRC slot filled in flight
          tx_q   <= {2'b01, cmd_index_i, cmd_arg_i, 7'h00, 1'b1};
          type_q <= rsp_type_i;
          crc_q  <= '0;
        end
      end
      ST_SEND: begin
        if (cnt_q >= CRC_POS) crc_q <= crc_nxt;
        if (cnt_q == CRC_POS) begin
          tx_q <= {crc_nxt, 1'b1, {(FRAME_BITS - 8){1'b0}}};  // CRC then end bit
        end else begin
          tx_q <= tx_q << 1;
        end
      end
      ST_WAIT: crc_q <= '0;
      default: begin
        rx_q <= {rx_q[FRAME_BITS-3:0], sd_cmd_dat_i};
        if (cnt_q >= CRC_POS) crc_q <= crc_nxt;  // Direction, index, argument
      end
    endcase
  end

  assign cmd_ready_o  = (state_q == ST_IDLE);
  assign sd_cmd_oe_o  = oe_q;
  assign sd_cmd_out_o = oe_q ? tx_q[FRAME_BITS-1] : 1'b1;  // Idle high
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_index_o  = rx_q[FRAME_BITS-3 -: 6];
  assign rsp_arg_o    = rx_q[FRAME_BITS-9 -: 32];
  assign crc_ok_o     = (rx_q[7:1] == crc_q);
  assign end_ok_o     = rx_q[0];
  assign timed_out_o  = timed_out_q;

  // Host never drives while the card may answer
  a_no_oe_rx: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (state_q == ST_WAIT || state_q == ST_RECV) |-> !sd_cmd_oe_o);

endmodule

//--- hw/sdc_resp_result.sv
`timescale 1ns/100ps

module sdc_resp_result import sdc_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             rst_i,
  input  logic             rsp_valid_i,
  input  rsp_type_e        rsp_type_i,
  input  logic             crc_chk_i,
  input  logic             idx_chk_i,
  input  logic [5:0]       cmd_index_i,
  input  logic [5:0]       rsp_index_i,
  input  resp_arg_u        rsp_arg_i,
  input  logic             crc_ok_i,
  input  logic             end_ok_i,
  input  logic             timed_out_i,
  input  logic [ISR_W-1:0] nisr_clr_i,
  input  logic [ISR_W-1:0] eisr_clr_i,
  input  logic [ISR_W-1:0] nien_i,
  input  logic [ISR_W-1:0] eien_i,
  output logic [ISR_W-1:0] nisr_o,
  output logic [ISR_W-1:0] eisr_o,
  output resp_arg_u        resp_o,
  output logic [3:0]       card_state_o,
  output logic             int_o
);

  logic             has_rsp;    // A frame actually arrived
  logic             crc_err;
  logic             idx_err;
  logic             end_err;
  logic [ISR_W-1:0] ni_set;
  logic [ISR_W-1:0] ei_set;
  logic [3:0]       state_dec;
  logic [ISR_W-1:0] nisr_q;
  logic [ISR_W-1:0] eisr_q;
  resp_arg_u        resp_q;
  logic [3:0]       card_q;

  assign has_rsp = (rsp_type_i != RSP_NONE) && !timed_out_i;
  // R3 carries no real CRC or index
  assign crc_err = has_rsp && (rsp_type_i == RSP_R1) && crc_chk_i && !crc_ok_i;
  assign idx_err = has_rsp && (rsp_type_i == RSP_R1) && idx_chk_i &&
                   (rsp_index_i != cmd_index_i);
  assign end_err = has_rsp && !end_ok_i;

  always_comb begin
    ei_set              = '0;
    ei_set[EI_TIMEOUT]  = timed_out_i;
    ei_set[EI_CRC]      = crc_err;
    ei_set[EI_END]      = end_err;
    ei_set[EI_INDEX]    = idx_err;
    ni_set              = '0;
    ni_set[NI_CMD_DONE] = 1'b1;     // Every response, good or bad
    ni_set[NI_ERR]      = |ei_set;
  end

  // Same word, two readings
  always_comb begin
    if (rsp_type_i == RSP_R3) begin
      state_dec = {3'b000, rsp_arg_i.ocr.pwr_busy};
    end else begin
      state_dec = rsp_arg_i.r1.cur_state;
    end
  end

  ////////////////////////////////////////
  // Status registers
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      nisr_q <= '0;
      eisr_q <= '0;
    end else begin
      // New event wins over a clear in the same cycle
      nisr_q <= (nisr_q & ~nisr_clr_i) | (rsp_valid_i ? ni_set : '0);
      eisr_q <= (eisr_q & ~eisr_clr_i) | (rsp_valid_i ? ei_set : '0);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rsp_valid_i && has_rsp) begin
      resp_q <= rsp_arg_i;
      card_q <= state_dec;
    end
  end

  assign nisr_o       = nisr_q;
  assign eisr_o       = eisr_q;
  assign resp_o       = resp_q;
  assign card_state_o = card_q;
  assign int_o        = |(nisr_q & nien_i) | |(eisr_q & eien_i);

  // Status only rises right after a response
  a_isr_rise: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    ((nisr_q & ~$past(nisr_q)) != '0 || (eisr_q & ~$past(eisr_q)) != '0)
      |-> $past(rsp_valid_i));

endmodule

//--- hw/sdc_cmd_top.sv
`timescale 1ns/100ps

module sdc_cmd_top import sdc_pkg::*; #(
  parameter int TIMEOUT_W = 16
) (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic [7:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic        wb_ack_o,
  input  logic        sd_cmd_dat_i,
  output logic        sd_cmd_out_o,
  output logic        sd_cmd_oe_o,
  output logic        int_o
);

  // Decode to execute
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [5:0]           cmd_index;
  logic [31:0]          cmd_arg;
  rsp_type_e            rsp_type;
  logic                 crc_chk;
  logic                 idx_chk;
  logic [TIMEOUT_W-1:0] timeout;
  // Execute to result
  logic                 rsp_valid;
  logic [5:0]           rsp_index;
  resp_arg_u            rsp_arg;
  logic                 crc_ok;
  logic                 end_ok;
  logic                 timed_out;
  // Decode and result
  logic [ISR_W-1:0]     nisr_clr;
  logic [ISR_W-1:0]     eisr_clr;
  logic [ISR_W-1:0]     nien;
  logic [ISR_W-1:0]     eien;
  logic [ISR_W-1:0]     nisr;
  logic [ISR_W-1:0]     eisr;
  resp_arg_u            resp;
  logic [3:0]           card_state;

  sdc_reg_decode #(.TIMEOUT_W(TIMEOUT_W)) u_decode (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .cmd_ready_i(cmd_ready), .rsp_valid_i(rsp_valid),
    .nisr_i(nisr), .eisr_i(eisr), .resp_i(resp), .card_state_i(card_state),
    .cmd_valid_o(cmd_valid), .cmd_index_o(cmd_index), .cmd_arg_o(cmd_arg),
    .rsp_type_o(rsp_type), .crc_chk_o(crc_chk), .idx_chk_o(idx_chk), .timeout_o(timeout),
    .nisr_clr_o(nisr_clr), .eisr_clr_o(eisr_clr), .nien_o(nien), .eien_o(eien)
  );

  sdc_cmd_serial #(.TIMEOUT_W(TIMEOUT_W)) u_serial (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .cmd_valid_i(cmd_valid),
    .cmd_index_i(cmd_index), .cmd_arg_i(cmd_arg), .rsp_type_i(rsp_type),
    .timeout_i(timeout), .sd_cmd_dat_i(sd_cmd_dat_i),
    .cmd_ready_o(cmd_ready), .sd_cmd_out_o(sd_cmd_out_o), .sd_cmd_oe_o(sd_cmd_oe_o),
    .rsp_valid_o(rsp_valid), .rsp_index_o(rsp_index), .rsp_arg_o(rsp_arg),
    .crc_ok_o(crc_ok), .end_ok_o(end_ok), .timed_out_o(timed_out)
  );

  sdc_resp_result u_result (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .rsp_valid_i(rsp_valid), .rsp_type_i(rsp_type),
    .crc_chk_i(crc_chk), .idx_chk_i(idx_chk), .cmd_index_i(cmd_index),
    .rsp_index_i(rsp_index), .rsp_arg_i(rsp_arg), .crc_ok_i(crc_ok), .end_ok_i(end_ok),
    .timed_out_i(timed_out), .nisr_clr_i(nisr_clr), .eisr_clr_i(eisr_clr),
    .nien_i(nien), .eien_i(eien), .nisr_o(nisr), .eisr_o(eisr), .resp_o(resp),
    .card_state_o(card_state), .int_o(int_o)
  );

endmodule

//--- verif/sdc_card_model.sv
`timescale 1ns/100ps

module sdc_card_model import sdc_pkg::*; (
  input  logic                  wb_clk_i,
  input  logic                  cmd_out_i,       // Host CMD drive
  input  logic                  cmd_oe_i,
  output logic                  cmd_dat_o,       // Line as the host sees it
  input  logic                  rsp_en_i,        // Answer the next token
  input  logic [5:0]            rsp_index_i,
  input  logic [31:0]           rsp_arg_i,
  input  logic [1:0]            crc_mode_i,      // 0 good, 1 flipped bit, 2 all ones
  input  logic [3:0]            delay_i,         // Cycles before start bit
  output logic [FRAME_BITS-1:0] token_o,         // Last captured token
  output int                    token_cnt_o,
  output int                    token_len_o,     // Cycles with oe high
  output logic                  token_crc_ok_o
);

  // CRC7 of frame bits 47:8, MSB first, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'b000_1001;
    end
    return crc;
  endfunction

  logic [FRAME_BITS-1:0] tok_sr;
  logic [FRAME_BITS-1:0] rsp_frame;
  logic [6:0]            rsp_crc;
  int                    len;

  ////////////////////////////////////////
  // Capture on falling edge, answer on falling edge
  ////////////////////////////////////////
  initial begin
    cmd_dat_o      = 1'b1;  // Pulled up while nobody drives
    token_o        = '0;
    token_cnt_o    = 0;
    token_len_o    = 0;
    token_crc_ok_o = 1'b0;
    tok_sr         = '0;
    len            = 0;
    forever begin
      @(negedge wb_clk_i);
      if (cmd_oe_i) begin
        tok_sr = {tok_sr[FRAME_BITS-2:0], cmd_out_i};
        len++;
      end else if (len != 0) begin
        // Token just ended
        token_o        = tok_sr;
        token_len_o    = len;
        token_crc_ok_o = (tok_sr[7:1] == crc7_of(tok_sr[47:8]));
        token_cnt_o++;
        len = 0;
        if (rsp_en_i) begin
          rsp_crc = crc7_of({2'b00, rsp_index_i, rsp_arg_i});  // Card direction bit 0
          if (crc_mode_i == 2'd1) begin
            rsp_crc = rsp_crc ^ 7'h01;
          end else if (crc_mode_i == 2'd2) begin
            rsp_crc = 7'h7F;                                 // R3 style
          end
          rsp_frame = {2'b00, rsp_index_i, rsp_arg_i, rsp_crc, 1'b1};
          repeat (delay_i) @(negedge wb_clk_i);
          for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            cmd_dat_o = rsp_frame[i];
            @(negedge wb_clk_i);
          end
          cmd_dat_o = 1'b1;  // Release
        end
      end
    end
  end

endmodule

//--- verif/sdc_cmd_tb.sv
`timescale 1ns/100ps

module sdc_cmd_tb import sdc_pkg::*; ();

  localparam int N_TESTS   = 8;    // Data lines in stimulus file
  localparam int CLK_NS    = 8;
  localparam int TMO_CYC   = 40;   // Well above the longest card delay
  localparam int MAX_DELAY = 15;
  localparam int POLL_MAX  = 200;  // NISR reads before giving up
  localparam int WD_CYC    = N_TESTS * (2 * FRAME_BITS + MAX_DELAY + TMO_CYC + 200) + 100;

  logic        wb_clk_i;
  logic        rst_i;
  logic [7:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic        sd_cmd_dat;
  logic        sd_cmd_out;
  logic        sd_cmd_oe;
  logic        int_o;
  // Card control and capture
  logic        card_rsp_en;
  logic [5:0]  card_rsp_index;
  logic [31:0] card_rsp_arg;
  logic [1:0]  card_crc_mode;
  logic [3:0]  card_delay;
  logic [FRAME_BITS-1:0] token;
  int          token_cnt;
  int          token_len;
  logic        token_crc_ok;

  logic [115:0] stim_mem [0:N_TESTS-1];  // arg set rsp ridx rarg crc eisr card
  logic [15:0]  lfsr_q;
  logic [31:0]  exp_resp;                // Last argument the card sent

  sdc_cmd_top #(.TIMEOUT_W(16)) u_dut (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o), .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_ack_o(wb_ack_o), .sd_cmd_dat_i(sd_cmd_dat), .sd_cmd_out_o(sd_cmd_out),
    .sd_cmd_oe_o(sd_cmd_oe), .int_o(int_o)
  );

  sdc_card_model u_card (
    .wb_clk_i(wb_clk_i), .cmd_out_i(sd_cmd_out), .cmd_oe_i(sd_cmd_oe), .cmd_dat_o(sd_cmd_dat),
    .rsp_en_i(card_rsp_en), .rsp_index_i(card_rsp_index), .rsp_arg_i(card_rsp_arg),
    .crc_mode_i(card_crc_mode), .delay_i(card_delay), .token_o(token),
    .token_cnt_o(token_cnt), .token_len_o(token_len), .token_crc_ok_o(token_crc_ok)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_NS / 2) wb_clk_i = ~wb_clk_i;
  end

  initial begin  // Watchdog
    #(WD_CYC * CLK_NS);
    $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYC);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog");
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic expect_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic draw_delay(output logic [3:0] d);
    logic [3:0] raw;
    for (int i = 0; i < 4; i++) begin
      raw[i] = lfsr_q[0];  // One step per bit
      lfsr_q = lfsr_step(lfsr_q);
    end
    d = 4'(2 + raw % 14);  // 2 to 15
  endtask

  // One Wishbone access driven on falling edges
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waits;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    waits    = 0;
    do begin
      @(negedge wb_clk_i);
      waits++;
    end while (!wb_ack_o && waits < 8);
    if (!wb_ack_o) fail_run($sformatf("No Wishbone acknowledge at address %h", adr));
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic compare_reg(input string what, input logic [7:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_access(1'b0, adr, '0, rd);
    expect_equal(what, rd, exp);
  endtask

  // Poll for NI_CMD_DONE
  task automatic wait_cmd_done();
    logic [31:0] rd;
    int          polls;
    polls = 0;
    do begin
      wb_access(1'b0, ADR_NISR, '0, rd);
      polls++;
    end while (!rd[NI_CMD_DONE] && polls < POLL_MAX);
    if (!rd[NI_CMD_DONE]) fail_run("Command never completed, NI_CMD_DONE stayed low");
  endtask

  ////////////////////////////////////////
  // One stimulus line
  ////////////////////////////////////////
  task automatic run_test(input int t);
    logic [31:0] arg;
    logic [15:0] set;
    logic [3:0]  rsp;
    logic [7:0]  ridx;
    logic [31:0] rarg;
    logic [3:0]  crcm;
    logic [15:0] exp_eisr;
    logic [3:0]  exp_card;
    logic [15:0] exp_nisr;
    logic [15:0] nien;
    logic [15:0] eien;
    int          cnt_before;
    {arg, set, rsp, ridx, rarg, crcm, exp_eisr, exp_card} = stim_mem[t];
    nien = (t % 2 == 1) ? 16'h0001 : ((t % 4 == 2) ? 16'h0000 : 16'h8000);  // Vary the enables
    eien = (t % 8 < 4) ? 16'h000F : 16'h0000;
    exp_nisr              = '0;
    exp_nisr[NI_CMD_DONE] = 1'b1;
    exp_nisr[NI_ERR]      = (exp_eisr != '0);
    card_rsp_en    = rsp[0];
    card_rsp_index = ridx[5:0];
    card_rsp_arg   = rarg;
    card_crc_mode  = crcm[1:0];
    draw_delay(card_delay);
    if (rsp[0]) exp_resp = rarg;
    write_reg(ADR_NIEN, 32'(nien));
    write_reg(ADR_EIEN, 32'(eien));
    write_reg(ADR_ARG, arg);
    cnt_before = token_cnt;
    write_reg(ADR_CMD, 32'(set));
    write_reg(ADR_CMD, 32'(set ^ 16'h2A00));  // Lands while busy and must be dropped
    compare_reg("status busy", ADR_STATUS, 32'd1);
    wait_cmd_done();
    // Token on the line
    expect_equal("CMD line released", sd_cmd_oe, 1'b0);
    expect_equal("token count", token_cnt, cnt_before + 1);
    expect_equal("token length", token_len, FRAME_BITS);
    expect_equal("token start, direction, index", token[47:40], {2'b01, set[13:8]});
    expect_equal("token argument", token[39:8], arg);
    expect_equal("token CRC7 ok", token_crc_ok, 1'b1);
    expect_equal("token end bit", token[0], 1'b1);
    // Result registers
    compare_reg("nisr", ADR_NISR, 32'(exp_nisr));
    compare_reg("eisr", ADR_EISR, 32'(exp_eisr));
    compare_reg("status idle", ADR_STATUS, 32'd0);
    compare_reg("response", ADR_RESP, exp_resp);
    compare_reg("card state", ADR_CARD, 32'(exp_card));
    expect_equal("int_o", int_o, (|(exp_nisr & nien)) | (|(exp_eisr & eien)));
    // Write ones to clear
    write_reg(ADR_NISR, 32'h0000_FFFF);
    write_reg(ADR_EISR, 32'h0000_FFFF);
    compare_reg("nisr cleared", ADR_NISR, 32'd0);
    compare_reg("eisr cleared", ADR_EISR, 32'd0);
    expect_equal("int_o after clear", int_o, 1'b0);
  endtask

  initial begin
    rst_i          = 1'b1;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    wb_we_i        = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    card_rsp_en    = 1'b0;
    card_rsp_index = '0;
    card_rsp_arg   = '0;
    card_crc_mode  = '0;
    card_delay     = 4'd2;
    exp_resp       = '0;
    lfsr_q         = 16'd77;  // Seed
    $readmemh("verif/sdc_cmd_stimulus.txt", stim_mem);
    repeat (4) @(negedge wb_clk_i);
    rst_i = 1'b0;
    expect_equal("wb_ack_o after reset", wb_ack_o, 1'b0);
    expect_equal("sd_cmd_oe_o after reset", sd_cmd_oe, 1'b0);
    expect_equal("sd_cmd_out_o after reset", sd_cmd_out, 1'b1);
    expect_equal("int_o after reset", int_o, 1'b0);
    compare_reg("status after reset", ADR_STATUS, 32'd0);
    compare_reg("nisr after reset", ADR_NISR, 32'd0);
    compare_reg("eisr after reset", ADR_EISR, 32'd0);
    write_reg(ADR_TIMEOUT, TMO_CYC);
    compare_reg("timeout", ADR_TIMEOUT, TMO_CYC);
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verif/sdc_cmd_stimulus.txt
// arg      set  r ridx rarg     c eisr card
// r card answers, c CRC sent (0 good, 1 one bit flipped, 2 all ones)
12345678_1119_1_11_00000900_0_0000_4
00FF8000_291A_1_3F_80FF8000_2_0000_1
00010000_0D19_1_0D_00000A00_1_0002_5
00010000_0D11_1_0D_00000600_1_0000_3
00010000_0D19_1_0C_00001E00_0_0008_F
00010000_0D09_1_0C_00000200_0_0000_1
000001AA_0819_0_00_00000000_0_0001_1
00000000_0000_0_00_00000000_0_0000_1

//--- flist.f
common/sdc_pkg.sv
hw/sdc_reg_decode.sv
cmd_phy/sdc_cmd_serial.sv
hw/sdc_resp_result.sv
hw/sdc_cmd_top.sv
verif/sdc_card_model.sv
verif/sdc_cmd_tb.sv
